/* Bender.yml */
package:
  name: yaw_angle_accumulator

sources:
  - yaw_pkg.sv
  - yaw_step_sequencer.sv
  - yaw_stick_conditioner.sv
  - yaw_target_tracker.sv
  - yaw_error_limiter.sv
  - yaw_angle_accumulator.sv
  - target: test
    files:
      - yaw_angle_accumulator_chk.sv
      - tb_yaw_angle_accumulator.sv

/* filelist.f */
yaw_pkg.sv
yaw_step_sequencer.sv
yaw_stick_conditioner.sv
yaw_target_tracker.sv
yaw_error_limiter.sv
yaw_angle_accumulator.sv
yaw_angle_accumulator_chk.sv
tb_yaw_angle_accumulator.sv

/* tb_yaw_angle_accumulator.sv */
// ------------------------------
// Testbench for the yaw angle accumulator
// Clock, reset and input drive
// Stimulus table with expected results
// Compare tasks and closing report
// ------------------------------
`default_nettype none

module tb_yaw_angle_accumulator;
	import yaw_pkg::*;

	// One table row, applied runs times; expected values hold for the last run
	typedef struct packed {
		rec_val_t   throttle;
		rec_val_t   yaw;
		angle_t     imu;
		logic       enable_n;
		logic [5:0] runs;
		angle_t     exp_target;
		angle_t     exp_error;
		logic       exp_window;
	} row_t;

	logic     us_clk;
	logic     resetn;
	rec_val_t throttle_pwm_value;
	rec_val_t yaw_pwm_value;
	angle_t   yaw_angle_imu;
	logic     yaac_enable_n;
	logic     start_signal;
	angle_t   body_yaw_angle_target;
	angle_t   yaw_angle_error_out;
	logic     yaw_stick_out_of_neutral_window;
	logic     active_signal;
	logic     complete_signal;

	row_t rows [0:15];
	int   num_rows;
	int   mismatch_count;
	int   timeout_count;

	yaw_angle_accumulator i_yaw_angle_accumulator (
		.us_clk                          (us_clk),
		.resetn                          (resetn),
		.throttle_pwm_value              (throttle_pwm_value),
		.yaw_pwm_value                   (yaw_pwm_value),
		.yaw_angle_imu                   (yaw_angle_imu),
		.yaac_enable_n                   (yaac_enable_n),
		.start_signal                    (start_signal),
		.body_yaw_angle_target           (body_yaw_angle_target),
		.yaw_angle_error_out             (yaw_angle_error_out),
		.yaw_stick_out_of_neutral_window (yaw_stick_out_of_neutral_window),
		.active_signal                   (active_signal),
		.complete_signal                 (complete_signal)
	);

	initial begin
		us_clk = 1'b0;
		forever #2 us_clk = ~us_clk;
	end

	task automatic add_row(input rec_val_t throttle, input rec_val_t yaw, input angle_t imu,
		input logic enable_n, input int runs, input angle_t exp_target,
		input angle_t exp_error, input logic exp_window);
		row_t r;
		r.throttle   = throttle;
		r.yaw        = yaw;
		r.imu        = imu;
		r.enable_n   = enable_n;
		r.runs       = runs[5:0];
		r.exp_target = exp_target;
		r.exp_error  = exp_error;
		r.exp_window = exp_window;
		rows[num_rows] = r;
		num_rows++;
	endtask

	task automatic compare_angle(input string name, input angle_t actual, input angle_t expected);
		if (actual !== expected) begin
			$display("mismatch %s: got 0x%04h expected 0x%04h", name, actual, expected);
			mismatch_count++;
		end
	endtask

	task automatic compare_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("mismatch %s: got 0x%0h expected 0x%0h", name, actual, expected);
			mismatch_count++;
		end
	endtask

	// One start pulse, then wait for complete
	task automatic run_once(input row_t r, output logic done);
		int cycles;
		@(negedge us_clk);
		throttle_pwm_value = r.throttle;
		yaw_pwm_value      = r.yaw;
		yaw_angle_imu      = r.imu;
		yaac_enable_n      = r.enable_n;
		start_signal       = 1'b1;
		@(negedge us_clk);
		start_signal = 1'b0;
		cycles = 0;
		done   = 1'b0;
		while (!done && cycles < 20) begin
			@(negedge us_clk);
			done = complete_signal;
			cycles++;
		end
	endtask

	initial begin
		int   i;
		int   n;
		logic done;
		logic timed_out;

		throttle_pwm_value = '0;
		yaw_pwm_value      = '0;
		yaw_angle_imu      = '0;
		yaac_enable_n      = 1'b0;
		start_signal       = 1'b0;
		resetn             = 1'b0;
		num_rows           = 0;
		mismatch_count     = 0;
		timeout_count      = 0;
		timed_out          = 1'b0;

		// Neutral, tracking and previous error carry from row to row
		add_row(0,   128, 1600, 0, 1,  1600, 0,    0);
		add_row(100, 130, 1620, 0, 1,  1600, -20,  0);
		add_row(100, 168, 1600, 0, 1,  1610, 10,   1);
		add_row(100, 28,  1300, 0, 1,  1585, 60,   1);
		// Ramp the previous error past 90 degrees
		add_row(100, 128, 0,    0, 28, 1585, 1440, 0);
		// Jump from above +90 to below -90 holds at +90
		add_row(100, 128, 3200, 0, 1,  1585, 1440, 0);
		add_row(0,   128, 16,   0, 1,  16,   1390, 0);
		// Tracking wraps below zero, crossover error
		add_row(100, 0,   16,   0, 1,  5744, 1340, 1);
		add_row(100, 128, 16,   0, 28, 5744, -32,  0);
		// Tracking wraps above 360, mirrored crossover
		add_row(100, 255, 5700, 0, 1,  15,   18,   1);
		add_row(100, 128, 5700, 0, 2,  15,   75,   0);
		// Bypass
		add_row(100, 200, 100,  1, 1,  200,  0,    1);
		add_row(100, 128, 40,   0, 1,  33,   -7,   0);
		// Edges of the neutral band
		add_row(100, 132, 40,   0, 1,  34,   -6,   1);
		add_row(100, 125, 40,   0, 1,  34,   -6,   0);

		repeat (5) @(negedge us_clk);
		resetn = 1'b1;

		for (i = 0; i < num_rows; i++) begin
			for (n = 0; n < rows[i].runs; n++) begin
				run_once(rows[i], done);
				if (!done) begin
					$display("complete_signal did not pulse after start in row %0d", i);
					timeout_count++;
					timed_out = 1'b1;
					break;
				end
			end
			if (timed_out)
				break;
			compare_angle("body_yaw_angle_target", body_yaw_angle_target, rows[i].exp_target);
			compare_angle("yaw_angle_error_out", yaw_angle_error_out, rows[i].exp_error);
			compare_flag("yaw_stick_out_of_neutral_window", yaw_stick_out_of_neutral_window,
				rows[i].exp_window);
			compare_flag("active_signal", active_signal, 1'b0);
		end

		$display("Run finished: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* yaw_angle_accumulator.sv */
// ------------------------------
// Yaw angle accumulator top level
// Sequencer, stick conditioner,
// target tracker and error limiter
// ------------------------------
`default_nettype none

module yaw_angle_accumulator
	import yaw_pkg::*;
#(
	parameter int SCALE_BITS       = 2,
	parameter int ERROR_MAX_CHANGE = 50
) (
	input  wire      us_clk,
	input  wire      resetn,
	input  rec_val_t throttle_pwm_value,
	input  rec_val_t yaw_pwm_value,
	input  angle_t   yaw_angle_imu,
	input  logic     yaac_enable_n,
	input  logic     start_signal,
	output angle_t   body_yaw_angle_target,
	output angle_t   yaw_angle_error_out,
	output logic     yaw_stick_out_of_neutral_window,
	output logic     active_signal,
	output logic     complete_signal
);

	yaw_step_e      step;
	stick_sample_t  stick;
	target_sample_t target_s;

	yaw_step_sequencer i_yaw_step_sequencer (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.start_signal    (start_signal),
		.step            (step),
		.active_signal   (active_signal),
		.complete_signal (complete_signal)
	);

	yaw_stick_conditioner i_yaw_stick_conditioner (
		.us_clk             (us_clk),
		.resetn             (resetn),
		.step               (step),
		.throttle_pwm_value (throttle_pwm_value),
		.yaw_pwm_value      (yaw_pwm_value),
		.yaw_angle_imu      (yaw_angle_imu),
		.stick              (stick)
	);

	yaw_target_tracker #(
		.SCALE_BITS (SCALE_BITS)
	) i_yaw_target_tracker (
		.us_clk   (us_clk),
		.resetn   (resetn),
		.step     (step),
		.stick    (stick),
		.target_s (target_s)
	);

	yaw_error_limiter #(
		.ERROR_MAX_CHANGE (ERROR_MAX_CHANGE)
	) i_yaw_error_limiter (
		.us_clk                (us_clk),
		.resetn                (resetn),
		.step                  (step),
		.target_s              (target_s),
		.yaac_enable_n         (yaac_enable_n),
		.body_yaw_angle_target (body_yaw_angle_target),
		.yaw_angle_error_out   (yaw_angle_error_out)
	);

	// Window flag straight from the conditioner
	assign yaw_stick_out_of_neutral_window = stick.out_of_window;

endmodule

`default_nettype wire

/* yaw_angle_accumulator_chk.sv */
// ------------------------------
// Sequencer timing assertions
// Complete pulse width, active/complete overlap
// Start to complete latency
// ------------------------------
`default_nettype none

module yaw_angle_accumulator_chk
	import yaw_pkg::*;
(
	input wire       us_clk,
	input wire       resetn,
	input logic      start_signal,
	input yaw_step_e step,
	input logic      active_signal,
	input logic      complete_signal
);

	complete_one_cycle: assert property (@(posedge us_clk) disable iff (!resetn)
		complete_signal |=> !complete_signal)
		else $error("complete_signal high for more than one cycle");

	no_active_with_complete: assert property (@(posedge us_clk) disable iff (!resetn)
		!(active_signal && complete_signal))
		else $error("active_signal and complete_signal high together");

	// Start taken in idle gives complete 8 edges later
	start_to_complete: assert property (@(posedge us_clk) disable iff (!resetn)
		(start_signal && step == STEP_IDLE) |-> ##8 complete_signal)
		else $error("complete_signal not 8 cycles after start");

endmodule

bind yaw_step_sequencer yaw_angle_accumulator_chk i_yaw_angle_accumulator_chk (
	.us_clk          (us_clk),
	.resetn          (resetn),
	.start_signal    (start_signal),
	.step            (step),
	.active_signal   (active_signal),
	.complete_signal (complete_signal)
);

`default_nettype wire

/* yaw_error_limiter.sv */
// ------------------------------
// Error limiter
// Wrapped yaw angle error with crossover handling
// Per-run change limit and +/-90 degree clamp
// Bypass and output registers
// ------------------------------
`default_nettype none

module yaw_error_limiter
	import yaw_pkg::*;
#(
	parameter int ERROR_MAX_CHANGE = 50
) (
	input  wire            us_clk,
	input  wire            resetn,
	input  yaw_step_e      step,
	input  target_sample_t target_s,
	input  logic           yaac_enable_n,
	output angle_t         body_yaw_angle_target,
	output angle_t         yaw_angle_error_out
);

	localparam angle_t MAX_CHANGE = angle_t'(ERROR_MAX_CHANGE);

	angle_t err;
	angle_t err_lim;
	angle_t prev_err;

	angle_t d;
	angle_t err_wrap;
	angle_t err_limit;
	angle_t err_clamp;
	logic   tgt_high_imu_low;
	logic   imu_high_tgt_low;

	// Wrapped error
	always_comb begin
		d = target_s.target - target_s.imu_angle;
		tgt_high_imu_low = (target_s.target > ANGLE_270) && (target_s.imu_angle < ANGLE_90);
		imu_high_tgt_low = (target_s.imu_angle > ANGLE_270) && (target_s.target < ANGLE_90);
		if (target_s.throttle_idle) begin
			err_wrap = '0;
		end else if (tgt_high_imu_low) begin
			// Target just left of north, heading just right of it
			if (d >= ANGLE_180)
				err_wrap = -(ANGLE_360 - target_s.target + target_s.imu_angle);
			else
				err_wrap = -(target_s.target - ANGLE_360 + target_s.imu_angle);
		end else if (imu_high_tgt_low) begin
			if (d <= -ANGLE_180)
				err_wrap = ANGLE_360 - target_s.imu_angle + target_s.target;
			else
				err_wrap = target_s.imu_angle - ANGLE_360 + target_s.target;
		end else if (d < -ANGLE_360) begin
			err_wrap = d + ANGLE_360;
		end else if (d > ANGLE_360) begin
			err_wrap = d - ANGLE_360;
		end else begin
			err_wrap = d;
		end
	end

	// Change limit against the last run, then the output clamp
	always_comb begin
		if ((prev_err >= ANGLE_90) && (err <= -ANGLE_90))
			err_limit = ANGLE_90;
		else if ((prev_err <= -ANGLE_90) && (err >= ANGLE_90))
			err_limit = -ANGLE_90;
		else if (err < (prev_err - MAX_CHANGE))
			err_limit = prev_err - MAX_CHANGE;
		else if (err > (prev_err + MAX_CHANGE))
			err_limit = prev_err + MAX_CHANGE;
		else
			err_limit = err;

		if (err_limit > ANGLE_90)
			err_clamp = ANGLE_90;
		else if (err_limit < -ANGLE_90)
			err_clamp = -ANGLE_90;
		else
			err_clamp = err_limit;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			err                   <= '0;
			err_lim               <= '0;
			prev_err              <= '0;
			body_yaw_angle_target <= '0;
			yaw_angle_error_out   <= '0;
		end else if (step == STEP_ERROR) begin
			err <= err_wrap;
		end else if (step == STEP_LIMIT) begin
			err_lim <= err_limit;
			if (yaac_enable_n) begin
				// Bypass passes the raw stick through
				body_yaw_angle_target <=
					angle_t'({{(ANGLE_WIDTH-REC_VAL_WIDTH){1'b0}}, target_s.raw_yaw});
				yaw_angle_error_out   <= '0;
			end else begin
				body_yaw_angle_target <= target_s.target;
				yaw_angle_error_out   <= err_clamp;
			end
		end else if (step == STEP_DONE) begin
			prev_err <= err_lim;
		end
	end

endmodule

`default_nettype wire

/* yaw_pkg.sv */
// ------------------------------
// Shared definitions for the yaw angle accumulator
// Receiver and angle widths and types
// Angle constants in 1/16 degree counts
// Throttle and stick thresholds
// Run step enum and stage result structs
// ------------------------------
`default_nettype none

package yaw_pkg;

	// Widths
	localparam int REC_VAL_WIDTH = 8;
	localparam int ANGLE_WIDTH   = 16;

	// Receiver value, unsigned
	typedef logic [REC_VAL_WIDTH-1:0] rec_val_t;

	// Signed angle with 4 fractional bits, 16 counts per degree
	typedef logic signed [ANGLE_WIDTH-1:0] angle_t;

	// Angle constants
	localparam angle_t ANGLE_360 = 16'sd5760;
	localparam angle_t ANGLE_270 = 16'sd4320;
	localparam angle_t ANGLE_180 = 16'sd2880;
	localparam angle_t ANGLE_90  = 16'sd1440;

	// Throttle below this counts as idle
	localparam rec_val_t IDLE_THROTTLE = 8'd10;

	// Normalized stick strictly inside +/- this is neutral
	localparam angle_t NEUTRAL_BAND = 16'sd4;

	// Run steps in order
	typedef enum logic [2:0] {
		STEP_IDLE   = 3'd0,
		STEP_LATCH  = 3'd1,
		STEP_STICK  = 3'd2,
		STEP_TRACK  = 3'd3,
		STEP_TARGET = 3'd4,
		STEP_ERROR  = 3'd5,
		STEP_LIMIT  = 3'd6,
		STEP_DONE   = 3'd7
	} yaw_step_e;

	// Stick conditioner result
	typedef struct packed {
		angle_t   imu_angle;
		angle_t   stick_norm;
		rec_val_t raw_yaw;
		logic     throttle_idle;
		logic     out_of_window;
	} stick_sample_t;

	// Target tracker result
	typedef struct packed {
		angle_t   target;
		angle_t   imu_angle;
		rec_val_t raw_yaw;
		logic     throttle_idle;
	} target_sample_t;

endpackage

`default_nettype wire

/* yaw_step_sequencer.sv */
// ------------------------------
// Run sequencer for the yaw angle accumulator
// Steps once per cycle from latch to done
// Drives the active level and complete pulse
// ------------------------------
`default_nettype none

module yaw_step_sequencer
	import yaw_pkg::*;
(
	input  wire       us_clk,
	input  wire       resetn,
	input  logic      start_signal,
	output yaw_step_e step,
	output logic      active_signal,
	output logic      complete_signal
);

	yaw_step_e step_next;

	// Next step
	always_comb begin
		case (step)
			STEP_IDLE: begin
				// Start only counts while idle
				if (start_signal)
					step_next = STEP_LATCH;
				else
					step_next = STEP_IDLE;
			end
			STEP_LATCH: begin
				step_next = STEP_STICK;
			end
			STEP_STICK: begin
				step_next = STEP_TRACK;
			end
			STEP_TRACK: begin
				step_next = STEP_TARGET;
			end
			STEP_TARGET: begin
				step_next = STEP_ERROR;
			end
			STEP_ERROR: begin
				step_next = STEP_LIMIT;
			end
			STEP_LIMIT: begin
				step_next = STEP_DONE;
			end
			STEP_DONE: begin
				step_next = STEP_IDLE;
			end
			default: begin
				step_next = STEP_IDLE;
			end
		endcase
	end

	// State and status registers
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			step            <= STEP_IDLE;
			active_signal   <= 1'b0;
			complete_signal <= 1'b0;
		end else begin
			step            <= step_next;
			// Active drops in the same cycle complete rises
			active_signal   <= (step_next != STEP_IDLE);
			complete_signal <= (step == STEP_DONE);
		end
	end

endmodule

`default_nettype wire

/* yaw_stick_conditioner.sv */
// ------------------------------
// Stick conditioner
// Latches yaw, IMU angle and the idle throttle flag
// Captures the neutral yaw value at idle throttle
// Normalizes the stick and flags the neutral window
// ------------------------------
`default_nettype none

module yaw_stick_conditioner
	import yaw_pkg::*;
(
	input  wire           us_clk,
	input  wire           resetn,
	input  yaw_step_e     step,
	input  rec_val_t      throttle_pwm_value,
	input  rec_val_t      yaw_pwm_value,
	input  angle_t        yaw_angle_imu,
	output stick_sample_t stick
);

	rec_val_t latched_yaw;
	angle_t   latched_imu;
	logic     throttle_idle;
	rec_val_t neutral;
	angle_t   stick_norm;
	logic     out_of_window;

	rec_val_t neutral_next;
	angle_t   norm_next;
	logic     window_next;

	// Neutral follows the stick while the throttle is idle
	always_comb begin
		neutral_next = throttle_idle ? latched_yaw : neutral;
		norm_next    = angle_t'({{(ANGLE_WIDTH-REC_VAL_WIDTH){1'b0}}, latched_yaw})
			- angle_t'({{(ANGLE_WIDTH-REC_VAL_WIDTH){1'b0}}, neutral_next});
		// Outside the open band and only with throttle on
		window_next  = !throttle_idle
			&& ((norm_next >= NEUTRAL_BAND) || (norm_next <= -NEUTRAL_BAND));
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			latched_yaw      <= '0;
			latched_imu      <= '0;
			throttle_idle    <= 1'b0;
			neutral          <= '0;
			stick_norm       <= '0;
			out_of_window    <= 1'b0;
		end else if (step == STEP_LATCH) begin
			latched_yaw      <= yaw_pwm_value;
			latched_imu      <= yaw_angle_imu;
			throttle_idle    <= (throttle_pwm_value < IDLE_THROTTLE);
		end else if (step == STEP_STICK) begin
			neutral          <= neutral_next;
			stick_norm       <= norm_next;
			out_of_window    <= window_next;
		end
	end

	// Result towards the tracker
	always_comb begin
		stick.imu_angle     = latched_imu;
		stick.stick_norm    = stick_norm;
		stick.raw_yaw       = latched_yaw;
		stick.throttle_idle = throttle_idle;
		stick.out_of_window = out_of_window;
	end

endmodule

`default_nettype wire

/* yaw_target_tracker.sv */
// ------------------------------
// Target tracker
// Scaled stick accumulator with 360 degree wrap
// Derives the body yaw target from it
// ------------------------------
`default_nettype none

module yaw_target_tracker
	import yaw_pkg::*;
#(
	parameter int SCALE_BITS = 2
) (
	input  wire            us_clk,
	input  wire            resetn,
	input  yaw_step_e      step,
	input  stick_sample_t  stick,
	output target_sample_t target_s
);

	// 360 degrees in the scaled domain
	localparam angle_t ANGLE_360_SCALED = angle_t'(ANGLE_360 <<< SCALE_BITS);

	angle_t tracking;
	angle_t track_sum;
	angle_t track_next;

	always_comb begin
		track_sum = tracking + stick.stick_norm;
		if (stick.throttle_idle) begin
			// Restart tracking from the current heading
			track_next = stick.imu_angle <<< SCALE_BITS;
		end else if (stick.out_of_window) begin
			if (track_sum > ANGLE_360_SCALED)
				track_next = track_sum - ANGLE_360_SCALED;
			else if (track_sum < 0)
				track_next = track_sum + ANGLE_360_SCALED;
			else
				track_next = track_sum;
		end else begin
			// Neutral stick holds the target and avoids drift
			track_next = tracking;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			tracking <= '0;
			target_s <= '0;
		end else if (step == STEP_TRACK) begin
			tracking <= track_next;
		end else if (step == STEP_TARGET) begin
			if (stick.throttle_idle)
				target_s.target <= stick.imu_angle;
			else
				target_s.target <= tracking >>> SCALE_BITS;
			target_s.imu_angle     <= stick.imu_angle;
			target_s.raw_yaw       <= stick.raw_yaw;
			target_s.throttle_idle <= stick.throttle_idle;
		end
	end

endmodule

`default_nettype wire
